//--- hw/bus_to_reg.sv
// Bridge from the host's four-phase req/ack port to a one-cycle register strobe
// Read data and error are captured at the end of the strobe and held under ack
module bus_to_reg (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              req_i,
  input  logic              we_i,
  input  periph_pkg::addr_t addr_i,
  input  periph_pkg::data_t wdata_i,
  input  periph_pkg::data_t reg_rdata_i,
  input  logic              reg_err_i,
  output logic              ack_o,
  output periph_pkg::data_t rdata_o,
  output logic              err_o,
  output logic              reg_valid_o,
  output logic              reg_we_o,
  output periph_pkg::addr_t reg_addr_o,
  output periph_pkg::data_t reg_wdata_o
);

  import periph_pkg::*;

  bridge_state_e state_q;
  bridge_state_e state_d;
  logic          req_q;
  logic          err_q;
  logic          we_q;
  addr_t         addr_q;
  data_t         wdata_q;
  data_t         rdata_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (req_q) begin
          state_d = ACCESS;
        end
      end
      ACCESS:  state_d = ACK;
      // Hold ack until the host lets go of req
      ACK: begin
        if (!req_q) begin
          state_d = RELEASE;
        end
      end
      RELEASE: state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= IDLE;
      req_q   <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      req_q   <= req_i;
      if (state_q == ACCESS) begin
        err_q <= reg_err_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && req_q) begin
      we_q    <= we_i;
      addr_q  <= addr_i;
      wdata_q <= wdata_i;
    end
    if (state_q == ACCESS) begin
      rdata_q <= reg_rdata_i;
    end
  end

  assign reg_valid_o = (state_q == ACCESS);
  assign reg_we_o    = we_q;
  assign reg_addr_o  = addr_q;
  assign reg_wdata_o = wdata_q;
  assign ack_o       = (state_q == ACK) || (state_q == RELEASE);
  assign rdata_o     = rdata_q;
  assign err_o       = err_q;

  a_ack_after_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $rose(ack_o) |-> $past(req_i))
    else $error("ack_o rose with no request pending");

  // One strobe per host access
  a_single_strobe: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    reg_valid_o |=> !reg_valid_o)
    else $error("reg_valid_o high for two cycles");

endmodule : bus_to_reg

//--- hw/gpio_ctrl.sv
// GPIO block with output and output-enable registers and rising-edge interrupts
// Status bits are sticky and cleared by writing 1
module gpio_ctrl #(
  parameter int unsigned NGPIO = 8
) (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                valid_i,
  input  logic                we_i,
  input  periph_pkg::offset_t offset_i,
  input  periph_pkg::data_t   wdata_i,
  input  logic [NGPIO-1:0]    gpio_i,
  output periph_pkg::data_t   rdata_o,
  output logic [NGPIO-1:0]    gpio_o,
  output logic [NGPIO-1:0]    gpio_en_o,
  output logic [NGPIO-1:0]    intr_o
);

  import periph_pkg::*;

  logic [NGPIO-1:0] out_q;
  logic [NGPIO-1:0] out_en_q;
  logic [NGPIO-1:0] intr_en_q;
  logic [NGPIO-1:0] status_q;
  logic [NGPIO-1:0] meta_q;
  logic [NGPIO-1:0] in_q;
  logic [NGPIO-1:0] prev_q;
  logic [NGPIO-1:0] rise;
  logic [NGPIO-1:0] clr;
  logic             wr;

  assign wr   = valid_i & we_i;
  assign rise = in_q & ~prev_q;
  assign clr  = (wr && offset_i == GPIO_INTR_STATUS) ? wdata_i[NGPIO-1:0] : '0;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      out_q     <= '0;
      out_en_q  <= '0;
      intr_en_q <= '0;
      status_q  <= '0;
      meta_q    <= '0;
      in_q      <= '0;
      prev_q    <= '0;
    end else begin
      meta_q   <= gpio_i;
      in_q     <= meta_q;
      prev_q   <= in_q;
      // New edge wins over a clear in the same cycle
      status_q <= (status_q & ~clr) | rise;
      if (wr && offset_i == GPIO_OUT) begin
        out_q <= wdata_i[NGPIO-1:0];
      end
      if (wr && offset_i == GPIO_OUT_EN) begin
        out_en_q <= wdata_i[NGPIO-1:0];
      end
      if (wr && offset_i == GPIO_INTR_EN) begin
        intr_en_q <= wdata_i[NGPIO-1:0];
      end
    end
  end

  always_comb begin
    case (offset_i)
      GPIO_OUT:         rdata_o = data_t'(out_q);
      GPIO_OUT_EN:      rdata_o = data_t'(out_en_q);
      GPIO_IN:          rdata_o = data_t'(in_q);
      GPIO_INTR_EN:     rdata_o = data_t'(intr_en_q);
      GPIO_INTR_STATUS: rdata_o = data_t'(status_q);
      default:          rdata_o = '0;
    endcase
  end

  assign gpio_o    = out_q;
  assign gpio_en_o = out_en_q;
  assign intr_o    = status_q & intr_en_q;

endmodule : gpio_ctrl

//--- hw/intr_ctrl.sv
// Interrupt controller with fixed priority by ID, claim/complete and a software bit
// Source 0 is reserved and the lowest enabled pending ID wins the claim
module intr_ctrl #(
  parameter int unsigned NGPIO    = 8,
  parameter int unsigned NEXT_INT = 4,
  localparam int unsigned NSRC    = 1 + NGPIO + 1 + NEXT_INT
) (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                valid_i,
  input  logic                we_i,
  input  periph_pkg::offset_t offset_i,
  input  periph_pkg::data_t   wdata_i,
  input  logic [NSRC-1:0]     intr_src_i,
  output periph_pkg::data_t   rdata_o,
  output logic                irq_o,
  output logic                msip_o
);

  import periph_pkg::*;

  localparam int unsigned IDW = $clog2(NSRC);

  logic [NSRC-1:0] pending_q;
  logic [NSRC-1:0] pending_d;
  logic [NSRC-1:0] in_service_q;
  logic [NSRC-1:0] in_service_d;
  logic [NSRC-1:0] enable_q;
  logic            msip_q;
  logic [IDW-1:0]  claim_id;
  logic            claim_rd;
  logic            complete_wr;

  assign claim_rd    = valid_i && !we_i && (offset_i == INTR_CLAIM);
  assign complete_wr = valid_i && we_i && (offset_i == INTR_CLAIM);

  // Scan from the top so the lowest ID is the last to assign
  always_comb begin
    claim_id = '0;
    for (int i = NSRC - 1; i > 0; i--) begin
      if (pending_q[i] && enable_q[i]) begin
        claim_id = IDW'(i);
      end
    end
  end

  // Gateway
  always_comb begin
    pending_d    = pending_q | (intr_src_i & ~in_service_q);
    in_service_d = in_service_q;
    for (int i = 1; i < NSRC; i++) begin
      if (claim_rd && claim_id == IDW'(i)) begin
        pending_d[i]    = 1'b0;
        in_service_d[i] = 1'b1;
      end
      if (complete_wr && wdata_i == data_t'(i)) begin
        in_service_d[i] = 1'b0;
      end
    end
    pending_d[0]    = 1'b0;
    in_service_d[0] = 1'b0;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pending_q    <= '0;
      in_service_q <= '0;
      enable_q     <= '0;
      msip_q       <= 1'b0;
    end else begin
      pending_q    <= pending_d;
      in_service_q <= in_service_d;
      if (valid_i && we_i && offset_i == INTR_ENABLE) begin
        enable_q <= wdata_i[NSRC-1:0];
      end
      if (valid_i && we_i && offset_i == INTR_MSIP) begin
        msip_q <= wdata_i[0];
      end
    end
  end

  always_comb begin
    case (offset_i)
      INTR_PENDING: rdata_o = data_t'(pending_q);
      INTR_ENABLE:  rdata_o = data_t'(enable_q);
      INTR_CLAIM:   rdata_o = data_t'(claim_id);
      INTR_MSIP:    rdata_o = data_t'(msip_q);
      default:      rdata_o = '0;
    endcase
  end

  assign irq_o  = |(pending_q & enable_q);
  assign msip_o = msip_q;

  a_src_limit: assert property (@(posedge clk_i) NSRC <= 32)
    else $error("intr_ctrl: %0d sources, at most 32 fit a data word", NSRC);

endmodule : intr_ctrl

//--- hw/mtimer.sv
// Machine timer, a 32-bit up counter with a compare interrupt
// Counts every cycle while enabled, a write to MTIME loads the counter
module mtimer (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                valid_i,
  input  logic                we_i,
  input  periph_pkg::offset_t offset_i,
  input  periph_pkg::data_t   wdata_i,
  output periph_pkg::data_t   rdata_o,
  output logic                intr_o
);

  import periph_pkg::*;

  logic  en_q;
  data_t mtime_q;
  data_t mtimecmp_q;
  logic  wr;

  assign wr = valid_i & we_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      en_q       <= 1'b0;
      mtime_q    <= '0;
      mtimecmp_q <= '1;
    end else begin
      if (wr && offset_i == TIMER_CTRL) begin
        en_q <= wdata_i[0];
      end
      // Load takes precedence over counting
      if (wr && offset_i == TIMER_MTIME) begin
        mtime_q <= wdata_i;
      end else if (en_q) begin
        mtime_q <= mtime_q + 32'd1;
      end
      if (wr && offset_i == TIMER_MTIMECMP) begin
        mtimecmp_q <= wdata_i;
      end
    end
  end

  always_comb begin
    case (offset_i)
      TIMER_CTRL:     rdata_o = data_t'(en_q);
      TIMER_MTIME:    rdata_o = mtime_q;
      TIMER_MTIMECMP: rdata_o = mtimecmp_q;
      default:        rdata_o = '0;
    endcase
  end

  assign intr_o = en_q && (mtime_q >= mtimecmp_q);

endmodule : mtimer

//--- hw/periph_pkg.sv
// Widths, register map and bridge states shared by the peripheral subsystem
// Import inside a module body, or use scoped names in a module header
package periph_pkg;

  typedef logic [31:0] data_t;
  typedef logic [11:0] addr_t;
  typedef logic [3:0]  sel_t;
  typedef logic [7:0]  offset_t;

  // Peripheral select codes in addr bits 11:8
  localparam sel_t SEL_INTR  = 4'd0;
  localparam sel_t SEL_GPIO  = 4'd1;
  localparam sel_t SEL_TIMER = 4'd2;

  // Interrupt controller
  localparam offset_t INTR_PENDING = 8'h00;
  localparam offset_t INTR_ENABLE  = 8'h04;
  localparam offset_t INTR_CLAIM   = 8'h08;
  localparam offset_t INTR_MSIP    = 8'h0C;

  // GPIO
  localparam offset_t GPIO_OUT         = 8'h00;
  localparam offset_t GPIO_OUT_EN      = 8'h04;
  localparam offset_t GPIO_IN          = 8'h08;
  localparam offset_t GPIO_INTR_EN     = 8'h0C;
  localparam offset_t GPIO_INTR_STATUS = 8'h10;

  // Machine timer
  localparam offset_t TIMER_CTRL     = 8'h00;
  localparam offset_t TIMER_MTIME    = 8'h04;
  localparam offset_t TIMER_MTIMECMP = 8'h08;

  typedef enum logic [1:0] {
    IDLE,
    ACCESS,
    ACK,
    RELEASE
  } bridge_state_e;

endpackage : periph_pkg

//--- hw/peripheral_subsystem.sv
// Top of the peripheral subsystem: host bridge, decoder and three peripherals
// Source vector is {ext, timer, gpio, reserved 0}, lowest ID first
module peripheral_subsystem #(
  parameter int unsigned NGPIO    = 8,
  parameter int unsigned NEXT_INT = 4
) (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              req_i,
  input  logic              we_i,
  input  periph_pkg::addr_t addr_i,
  input  periph_pkg::data_t wdata_i,
  input  logic [NEXT_INT-1:0] ext_intr_i,
  input  logic [NGPIO-1:0]  gpio_i,
  output logic              ack_o,
  output periph_pkg::data_t rdata_o,
  output logic              err_o,
  output logic              irq_o,
  output logic              msip_o,
  output logic              timer_intr_o,
  output logic [NGPIO-1:0]  gpio_o,
  output logic [NGPIO-1:0]  gpio_en_o
);

  import periph_pkg::*;

  localparam int unsigned NSRC = 1 + NGPIO + 1 + NEXT_INT;

  logic             reg_valid;
  logic             reg_we;
  addr_t            reg_addr;
  data_t            reg_wdata;
  data_t            reg_rdata;
  logic             reg_err;
  logic             intr_valid;
  logic             gpio_valid;
  logic             timer_valid;
  data_t            intr_rdata;
  data_t            gpio_rdata;
  data_t            timer_rdata;
  logic [NGPIO-1:0] gpio_intr;
  logic             timer_intr;
  logic [NSRC-1:0]  intr_src;

  // ID 0 stays low
  assign intr_src     = {ext_intr_i, timer_intr, gpio_intr, 1'b0};
  assign timer_intr_o = timer_intr;

  bus_to_reg u_bus_to_reg (
    .clk_i,
    .arst_n_i,
    .req_i,
    .we_i,
    .addr_i,
    .wdata_i,
    .reg_rdata_i (reg_rdata),
    .reg_err_i   (reg_err),
    .ack_o,
    .rdata_o,
    .err_o,
    .reg_valid_o (reg_valid),
    .reg_we_o    (reg_we),
    .reg_addr_o  (reg_addr),
    .reg_wdata_o (reg_wdata)
  );

  reg_demux u_reg_demux (
    .reg_valid_i   (reg_valid),
    .reg_addr_i    (reg_addr),
    .intr_rdata_i  (intr_rdata),
    .gpio_rdata_i  (gpio_rdata),
    .timer_rdata_i (timer_rdata),
    .intr_valid_o  (intr_valid),
    .gpio_valid_o  (gpio_valid),
    .timer_valid_o (timer_valid),
    .reg_rdata_o   (reg_rdata),
    .reg_err_o     (reg_err)
  );

  intr_ctrl #(
    .NGPIO    (NGPIO),
    .NEXT_INT (NEXT_INT)
  ) u_intr_ctrl (
    .clk_i,
    .arst_n_i,
    .valid_i    (intr_valid),
    .we_i       (reg_we),
    .offset_i   (reg_addr[7:0]),
    .wdata_i    (reg_wdata),
    .intr_src_i (intr_src),
    .rdata_o    (intr_rdata),
    .irq_o,
    .msip_o
  );

  gpio_ctrl #(
    .NGPIO (NGPIO)
  ) u_gpio_ctrl (
    .clk_i,
    .arst_n_i,
    .valid_i   (gpio_valid),
    .we_i      (reg_we),
    .offset_i  (reg_addr[7:0]),
    .wdata_i   (reg_wdata),
    .gpio_i,
    .rdata_o   (gpio_rdata),
    .gpio_o,
    .gpio_en_o,
    .intr_o    (gpio_intr)
  );

  mtimer u_mtimer (
    .clk_i,
    .arst_n_i,
    .valid_i  (timer_valid),
    .we_i     (reg_we),
    .offset_i (reg_addr[7:0]),
    .wdata_i  (reg_wdata),
    .rdata_o  (timer_rdata),
    .intr_o   (timer_intr)
  );

endmodule : peripheral_subsystem

//--- hw/reg_demux.sv
// Address decoder for the internal register strobe
// Routes the valid to one peripheral and returns its read data, or an error
module reg_demux (
  input  logic              reg_valid_i,
  input  periph_pkg::addr_t reg_addr_i,
  input  periph_pkg::data_t intr_rdata_i,
  input  periph_pkg::data_t gpio_rdata_i,
  input  periph_pkg::data_t timer_rdata_i,
  output logic              intr_valid_o,
  output logic              gpio_valid_o,
  output logic              timer_valid_o,
  output periph_pkg::data_t reg_rdata_o,
  output logic              reg_err_o
);

  import periph_pkg::*;

  sel_t sel;
  logic mapped;

  assign sel = reg_addr_i[11:8];

  always_comb begin
    intr_valid_o  = 1'b0;
    gpio_valid_o  = 1'b0;
    timer_valid_o = 1'b0;
    reg_rdata_o   = '0;
    mapped        = 1'b1;
    case (sel)
      SEL_INTR: begin
        intr_valid_o = reg_valid_i;
        reg_rdata_o  = intr_rdata_i;
      end
      SEL_GPIO: begin
        gpio_valid_o = reg_valid_i;
        reg_rdata_o  = gpio_rdata_i;
      end
      SEL_TIMER: begin
        timer_valid_o = reg_valid_i;
        reg_rdata_o   = timer_rdata_i;
      end
      // Unmapped select, nobody sees the access
      default: begin
        mapped = 1'b0;
      end
    endcase
  end

  assign reg_err_o = reg_valid_i & ~mapped;

endmodule : reg_demux

//--- run.sh
#!/usr/bin/env bash
# Build and run the peripheral subsystem simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_peripheral_subsystem \
  -f sim.f

out="$(./obj_dir/Vtb_peripheral_subsystem)"
echo "$out"

echo "$out" | grep -q "Test passed"

//--- sim.f
hw/periph_pkg.sv
hw/bus_to_reg.sv
hw/reg_demux.sv
hw/intr_ctrl.sv
hw/gpio_ctrl.sv
hw/mtimer.sv
hw/peripheral_subsystem.sv
testbench/tb_peripheral_subsystem.sv

//--- testbench/tb_peripheral_subsystem.sv
// Self-checking testbench for the peripheral subsystem
// Drives random register traffic over the req/ack port and checks it against a model
module tb_peripheral_subsystem;
  timeunit 1ns;
  timeprecision 1ps;

  import periph_pkg::*;

  localparam int unsigned NGPIO    = 8;
  localparam int unsigned NEXT_INT = 4;
  localparam int unsigned NSRC     = 1 + NGPIO + 1 + NEXT_INT;
  localparam int unsigned EXT_ID0  = NGPIO + 2;
  localparam int          NTXN     = 320;
  localparam realtime     WD_TIME  = 2.0 * NTXN * 10 * 20.0;

  logic                clk;
  logic                arst_n;
  logic                req;
  logic                we;
  addr_t               addr;
  data_t               wdata;
  logic [NEXT_INT-1:0] ext_intr;
  logic [NGPIO-1:0]    gpio_in;
  logic                ack;
  data_t               rdata;
  logic                err;
  logic                irq;
  logic                msip;
  logic                timer_intr;
  logic [NGPIO-1:0]    gpio_out;
  logic [NGPIO-1:0]    gpio_en;

  integer seed = 32'h2348_fa28;
  int     checks = 0;
  int     errors = 0;

  // Reference model state
  logic [NGPIO-1:0]    m_out = '0;
  logic [NGPIO-1:0]    m_out_en = '0;
  logic [NGPIO-1:0]    m_ien = '0;
  logic [NGPIO-1:0]    m_status = '0;
  logic [NGPIO-1:0]    m_gpio_pend = '0;
  logic [NSRC-1:0]     m_enable = '0;
  logic [NEXT_INT-1:0] m_ext_pend = '0;
  logic [NEXT_INT-1:0] m_ext_insvc = '0;
  data_t               m_cmp = '1;

  peripheral_subsystem #(.NGPIO(NGPIO), .NEXT_INT(NEXT_INT)) DUT (
    .clk_i        (clk),
    .arst_n_i     (arst_n),
    .req_i        (req),
    .we_i         (we),
    .addr_i       (addr),
    .wdata_i      (wdata),
    .ext_intr_i   (ext_intr),
    .gpio_i       (gpio_in),
    .ack_o        (ack),
    .rdata_o      (rdata),
    .err_o        (err),
    .irq_o        (irq),
    .msip_o       (msip),
    .timer_intr_o (timer_intr),
    .gpio_o       (gpio_out),
    .gpio_en_o    (gpio_en)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  task automatic check_data(input string name, input data_t exp, input data_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("FAIL %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("FAIL %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_gpio(input string name, input logic [NGPIO-1:0] exp,
                            input logic [NGPIO-1:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("FAIL %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // Four-phase access, entered and left 2 ns after a rising edge
  task automatic bus_access(input logic wr, input addr_t a, input data_t d,
                            output data_t rd, output logic er);
    req   = 1'b1;
    we    = wr;
    addr  = a;
    wdata = d;
    do begin
      @(posedge clk);
      #2;
    end while (!ack);
    rd  = rdata;
    er  = err;
    req = 1'b0;
    do begin
      @(posedge clk);
      #2;
    end while (ack);
  endtask

  task automatic write_reg(input sel_t sel, input offset_t off, input data_t d);
    data_t rd;
    logic  er;
    bus_access(1'b1, {sel, off}, d, rd, er);
    check_flag("write error flag", 1'b0, er);
  endtask

  task automatic read_reg(input sel_t sel, input offset_t off, output data_t rd);
    logic er;
    bus_access(1'b0, {sel, off}, '0, rd, er);
    check_flag("read error flag", 1'b0, er);
  endtask

  task automatic verify_regs(input string name);
    data_t rd;
    read_reg(SEL_GPIO, GPIO_OUT, rd);
    check_data({name, " GPIO_OUT"}, data_t'(m_out), rd);
    read_reg(SEL_GPIO, GPIO_OUT_EN, rd);
    check_data({name, " GPIO_OUT_EN"}, data_t'(m_out_en), rd);
    read_reg(SEL_GPIO, GPIO_INTR_EN, rd);
    check_data({name, " GPIO_INTR_EN"}, data_t'(m_ien), rd);
    read_reg(SEL_INTR, INTR_ENABLE, rd);
    check_data({name, " INTR_ENABLE"}, data_t'(m_enable), rd);
    read_reg(SEL_TIMER, TIMER_MTIMECMP, rd);
    check_data({name, " MTIMECMP"}, m_cmp, rd);
    check_gpio({name, " gpio_o"}, m_out, gpio_out);
    check_gpio({name, " gpio_en_o"}, m_out_en, gpio_en);
  endtask

  // Level sources set pending unless in service
  task automatic refresh_pending();
    m_ext_pend = m_ext_pend | (ext_intr & ~m_ext_insvc);
  endtask

  function automatic data_t lowest_claim();
    for (int i = 0; i < NEXT_INT; i++) begin
      if (m_ext_pend[i] && m_enable[EXT_ID0 + i]) begin
        return data_t'(EXT_ID0 + i);
      end
    end
    return '0;
  endfunction

  function automatic logic model_irq();
    return |(m_ext_pend & m_enable[EXT_ID0 +: NEXT_INT]);
  endfunction

  initial begin
    #(WD_TIME);
    $display("Watchdog expired, the bus handshake or a test sequence hung");
    $display("Test failed");
    $finish;
  end

  initial begin
    data_t            rd;
    data_t            d;
    data_t            prev;
    data_t            first;
    data_t            id;
    logic             er;
    logic [NGPIO-1:0] pins;
    logic [NGPIO-1:0] mask;
    sel_t             sel;

    arst_n   = 1'b0;
    req      = 1'b0;
    we       = 1'b0;
    addr     = '0;
    wdata    = '0;
    ext_intr = '0;
    gpio_in  = '0;
    repeat (5) @(posedge clk);
    #2;
    arst_n = 1'b1;
    check_flag("reset ack_o", 1'b0, ack);
    check_flag("reset err_o", 1'b0, err);
    check_flag("reset irq_o", 1'b0, irq);
    check_flag("reset msip_o", 1'b0, msip);
    check_flag("reset timer_intr_o", 1'b0, timer_intr);
    check_gpio("reset gpio_o", '0, gpio_out);
    check_gpio("reset gpio_en_o", '0, gpio_en);

    // Register write and readback
    for (int n = 0; n < 12; n++) begin
      m_out    = NGPIO'($random(seed));
      m_out_en = NGPIO'($random(seed));
      m_ien    = NGPIO'($random(seed));
      m_enable = NSRC'($random(seed));
      m_cmp    = data_t'($random(seed));
      write_reg(SEL_GPIO, GPIO_OUT, data_t'(m_out));
      write_reg(SEL_GPIO, GPIO_OUT_EN, data_t'(m_out_en));
      write_reg(SEL_GPIO, GPIO_INTR_EN, data_t'(m_ien));
      write_reg(SEL_INTR, INTR_ENABLE, data_t'(m_enable));
      write_reg(SEL_TIMER, TIMER_MTIMECMP, m_cmp);
      verify_regs("readback");
    end

    // Unmapped selects at offsets that exist in the mapped blocks
    for (int n = 0; n < 30; n++) begin
      sel = sel_t'(3 + ($unsigned($random(seed)) % 13));
      d   = data_t'($random(seed));
      bus_access(1'(n % 2), {sel, 8'({d[9:8], 2'b00})}, d, rd, er);
      check_flag("unmapped err_o", 1'b1, er);
      check_data("unmapped rdata", '0, rd);
    end
    verify_regs("after unmapped");

    // GPIO inputs and rising-edge status
    m_ien = NGPIO'($random(seed));
    write_reg(SEL_GPIO, GPIO_INTR_EN, data_t'(m_ien));
    for (int n = 0; n < 18; n++) begin
      pins    = NGPIO'($random(seed));
      m_status = m_status | (pins & ~gpio_in);
      gpio_in = pins;
      repeat (4) @(posedge clk);
      #2;
      m_gpio_pend = m_gpio_pend | (m_status & m_ien);
      read_reg(SEL_GPIO, GPIO_IN, rd);
      check_data("GPIO_IN", data_t'(pins), rd);
      read_reg(SEL_GPIO, GPIO_INTR_STATUS, rd);
      check_data("GPIO status", data_t'(m_status), rd);
      mask = NGPIO'($random(seed));
      write_reg(SEL_GPIO, GPIO_INTR_STATUS, data_t'(mask));
      m_status = m_status & ~mask;
      read_reg(SEL_GPIO, GPIO_INTR_STATUS, rd);
      check_data("GPIO status clear", data_t'(m_status), rd);
      read_reg(SEL_INTR, INTR_PENDING, rd);
      check_gpio("GPIO pin interrupts", m_gpio_pend, rd[NGPIO:1]);
    end

    // Timer
    write_reg(SEL_TIMER, TIMER_CTRL, 32'd0);
    d = data_t'($random(seed)) & 32'h00FF_FFFF;
    write_reg(SEL_TIMER, TIMER_MTIME, d);
    read_reg(SEL_TIMER, TIMER_MTIME, rd);
    check_data("MTIME disabled", d, rd);
    write_reg(SEL_TIMER, TIMER_CTRL, 32'd1);
    read_reg(SEL_TIMER, TIMER_MTIME, first);
    prev = first;
    for (int n = 0; n < 4; n++) begin
      read_reg(SEL_TIMER, TIMER_MTIME, rd);
      check_flag("MTIME increasing", 1'b1, rd > prev);
      prev = rd;
    end
    m_cmp = first;
    write_reg(SEL_TIMER, TIMER_MTIMECMP, m_cmp);
    check_flag("timer_intr_o compare hit", 1'b1, timer_intr);
    m_cmp = '1;
    write_reg(SEL_TIMER, TIMER_MTIMECMP, m_cmp);
    check_flag("timer_intr_o compare max", 1'b0, timer_intr);
    write_reg(SEL_TIMER, TIMER_CTRL, 32'd0);

    // Claim and complete on the external lines only
    m_enable = '0;
    m_enable[EXT_ID0 +: NEXT_INT] = NEXT_INT'($random(seed)) | NEXT_INT'(1);
    write_reg(SEL_INTR, INTR_ENABLE, data_t'(m_enable));
    for (int n = 0; n < 30; n++) begin
      if (n % 8 == 7) begin
        m_enable[EXT_ID0 +: NEXT_INT] = NEXT_INT'($random(seed));
        write_reg(SEL_INTR, INTR_ENABLE, data_t'(m_enable));
      end
      ext_intr = NEXT_INT'($random(seed));
      refresh_pending();
      id = lowest_claim();
      read_reg(SEL_INTR, INTR_CLAIM, rd);
      check_data("claim ID", id, rd);
      if (id != '0) begin
        m_ext_pend[id - EXT_ID0]  = 1'b0;
        m_ext_insvc[id - EXT_ID0] = 1'b1;
      end
      refresh_pending();
      check_flag("irq_o after claim", model_irq(), irq);
      if (id != '0 && $random(seed) % 4 != 0) begin
        write_reg(SEL_INTR, INTR_CLAIM, id);
        m_ext_insvc[id - EXT_ID0] = 1'b0;
        refresh_pending();
        check_flag("irq_o after complete", model_irq(), irq);
      end
    end
    write_reg(SEL_INTR, INTR_MSIP, 32'd1);
    check_flag("msip_o set", 1'b1, msip);
    write_reg(SEL_INTR, INTR_MSIP, 32'd0);
    check_flag("msip_o clear", 1'b0, msip);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule : tb_peripheral_subsystem
